//--- include/aes_params.svh
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 sizes in bits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define KEY_S  128
`define WORD_S 32
`define BYTE_S 8

// Words in the cipher key.
`define NK     4

// Cipher rounds, which also gives NR + 1 round keys.
`define NR     10

`endif

//--- source/aes_pkg.sv
`default_nettype none
`include "aes_params.svh"

package aes_pkg;

	// Byte 0 of a block sits in bits 127:120 and word 0 in bits 127:96, as in FIPS-197.
	typedef logic [`KEY_S-1:0]  block_t;
	typedef logic [`WORD_S-1:0] word_t;
	typedef logic [`BYTE_S-1:0] byte_t;
	typedef logic [3:0]         round_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Forward S-box, entry 0 first.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [0:255][`BYTE_S-1:0] sbox_table = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic byte_t sbox(input byte_t b);
		return sbox_table[b];
	endfunction

	// Round constant used when forming the key of round r.
	function automatic byte_t rcon(input round_t r);
		case (r)
			4'd1:    return 8'h01;
			4'd2:    return 8'h02;
			4'd3:    return 8'h04;
			4'd4:    return 8'h08;
			4'd5:    return 8'h10;
			4'd6:    return 8'h20;
			4'd7:    return 8'h40;
			4'd8:    return 8'h80;
			4'd9:    return 8'h1b;
			4'd10:   return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

	// Byte 0 is the leading byte of the word.
	function automatic byte_t get_byte(input word_t w, input logic [1:0] n);
		return w[`WORD_S-1-`BYTE_S*n -: `BYTE_S];
	endfunction

	function automatic byte_t xtime(input byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00); // Reduce by x^8 + x^4 + x^3 + x + 1.
	endfunction

endpackage

`default_nettype wire

//--- source/round_key_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

interface round_key_if;
	import aes_pkg::*;

	round_t addr;  // Round the key belongs to.
	block_t key;
	logic   w_e;
	logic   done;  // Pulses the cycle after round 10 is written.

	// Key expansion side.
	modport keygen (
		output addr,
		output key,
		output w_e,
		output done
	);

	modport store (
		input addr,
		input key,
		input w_e,
		input done
	);

	modport monitor (input done);
endinterface

`default_nettype wire

//--- source/round_key.sv
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module round_key (
	input wire                  clk,
	input wire                  reset,
	input wire                  en,
	input wire aes_pkg::block_t key,
	round_key_if.keygen         kif
);
	import aes_pkg::*;

	word_t  prev_w [0:`NK-1];
	word_t  next_w [0:`NK-1];
	word_t  sub_rot;
	block_t next_key;
	logic   last_write;

	assign last_write = kif.w_e && (kif.addr == round_t'(`NR));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Next round key from the one on the write port.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		for (int i = 0; i < `NK; i++) begin
			prev_w[i] = kif.key[`KEY_S-1-`WORD_S*i -: `WORD_S];
		end

		// RotWord, SubWord and Rcon on the last word.
		sub_rot = {
			sbox(get_byte(prev_w[`NK-1], 2'd1)),
			sbox(get_byte(prev_w[`NK-1], 2'd2)),
			sbox(get_byte(prev_w[`NK-1], 2'd3)),
			sbox(get_byte(prev_w[`NK-1], 2'd0))
		} ^ {rcon(kif.addr + 4'd1), 24'h000000};

		next_w[0] = prev_w[0] ^ sub_rot;
		for (int i = 1; i < `NK; i++) begin
			next_w[i] = next_w[i-1] ^ prev_w[i];
		end

		next_key = {next_w[0], next_w[1], next_w[2], next_w[3]};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			kif.addr <= '0;
			kif.w_e  <= 1'b0;
			kif.done <= 1'b0;
		end else begin
			kif.done <= last_write;

			if (en) begin
				kif.addr <= '0;   // Round 0 is the cipher key itself.
				kif.w_e  <= 1'b1;
			end else if (last_write) begin
				kif.w_e <= 1'b0;
			end else if (kif.w_e) begin
				kif.addr <= kif.addr + 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			kif.key <= key;
		end else if (kif.w_e && !last_write) begin
			kif.key <= next_key;
		end
	end

	assert property (@(posedge clk) disable iff (reset) kif.w_e |-> kif.addr <= round_t'(`NR))
		else $error("Round key write beyond round %0d.", `NR);

endmodule

`default_nettype wire

//--- source/key_store.sv
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module key_store (
	input wire                  clk,
	round_key_if.store          kif,
	input wire aes_pkg::round_t rd_addr,
	output aes_pkg::block_t     rd_key
);
	import aes_pkg::*;

	// One entry per round, 0 to NR.
	block_t keys [0:`NR];

	always_ff @(posedge clk) begin
		if (kif.w_e) begin
			keys[kif.addr] <= kif.key;
		end
	end

	assign rd_key = keys[rd_addr];  // Read is combinational for the round engine.

endmodule

`default_nettype wire

//--- source/cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module cmd_decode (
	input wire                  clk,
	input wire                  reset,
	input wire                  load_key,
	input wire                  encrypt,
	input wire aes_pkg::block_t key,
	input wire aes_pkg::block_t plaintext,
	input wire                  out_valid,
	round_key_if.monitor        kif,
	output logic                key_start,
	output aes_pkg::block_t     key_in,
	output logic                start,
	output aes_pkg::block_t     block_in,
	output logic                key_ready,
	output logic                busy
);
	import aes_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_expand,
		s_encrypt
	} state_t;

	state_t state;
	logic   take_load;
	logic   take_enc;

	// An encryption ends in its out_valid cycle, so a new strobe is taken there.
	assign busy = (state == s_expand) || ((state == s_encrypt) && !out_valid);

	assign take_load = load_key && !busy;
	assign take_enc  = encrypt && !load_key && !busy && key_ready; // A load wins a tie.

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= s_idle;
			key_ready <= 1'b0;
			key_start <= 1'b0;
			start     <= 1'b0;
		end else begin
			key_start <= take_load;
			start     <= take_enc;

			if (take_load) begin
				state     <= s_expand;
				key_ready <= 1'b0;  // Old round keys are about to be overwritten.
			end else if (take_enc) begin
				state <= s_encrypt;
			end else if ((state == s_expand) && kif.done) begin
				state     <= s_idle;
				key_ready <= 1'b1;
			end else if ((state == s_encrypt) && out_valid) begin
				state <= s_idle;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take_load) begin
			key_in <= key;
		end
		if (take_enc) begin
			block_in <= plaintext;
		end
	end

	assert property (@(posedge clk) disable iff (reset) !(key_start && start))
		else $error("Key expansion and encryption started together.");

	// Expansion finishes only while the decoder waits for it.
	assert property (@(posedge clk) disable iff (reset) kif.done |-> state == s_expand)
		else $error("Key expansion done outside a key load.");

endmodule

`default_nettype wire

//--- source/cipher_round.sv
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module cipher_round (
	input wire                  clk,
	input wire                  reset,
	input wire                  start,
	input wire aes_pkg::block_t block_in,
	output aes_pkg::round_t     rd_addr,
	input wire aes_pkg::block_t rd_key,
	output logic                final_valid,
	output aes_pkg::block_t     final_state
);
	import aes_pkg::*;

	localparam int n_bytes = `KEY_S / `BYTE_S;

	block_t state;
	block_t round_out;
	round_t round_no;
	logic   active;
	logic   last_round;
	byte_t  sub_b   [0:n_bytes-1];
	byte_t  shift_b [0:n_bytes-1];
	byte_t  mix_b   [0:n_bytes-1];

	assign rd_addr     = round_no;  // Idle count is 0, so the start cycle reads the round-0 key.
	assign last_round  = (round_no == round_t'(`NR));
	assign final_state = state;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// SubBytes, ShiftRows and MixColumns. Byte r + 4c is row r of column c.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		for (int i = 0; i < n_bytes; i++) begin
			sub_b[i] = sbox(state[`KEY_S-1-`BYTE_S*i -: `BYTE_S]);
		end

		// Row r moves left by r columns.
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shift_b[4*c+r] = sub_b[4*((c+r)%4)+r];
			end
		end

		for (int c = 0; c < 4; c++) begin
			mix_b[4*c]   = xtime(shift_b[4*c]) ^ xtime(shift_b[4*c+1]) ^ shift_b[4*c+1]
				^ shift_b[4*c+2] ^ shift_b[4*c+3];
			mix_b[4*c+1] = shift_b[4*c] ^ xtime(shift_b[4*c+1]) ^ xtime(shift_b[4*c+2])
				^ shift_b[4*c+2] ^ shift_b[4*c+3];
			mix_b[4*c+2] = shift_b[4*c] ^ shift_b[4*c+1] ^ xtime(shift_b[4*c+2])
				^ xtime(shift_b[4*c+3]) ^ shift_b[4*c+3];
			mix_b[4*c+3] = xtime(shift_b[4*c]) ^ shift_b[4*c] ^ shift_b[4*c+1]
				^ shift_b[4*c+2] ^ xtime(shift_b[4*c+3]);
		end

		// The final round has no MixColumns.
		for (int i = 0; i < n_bytes; i++) begin
			round_out[`KEY_S-1-`BYTE_S*i -: `BYTE_S] = last_round ? shift_b[i] : mix_b[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active      <= 1'b0;
			round_no    <= '0;
			final_valid <= 1'b0;
		end else begin
			final_valid <= active && last_round;

			if (start) begin
				active   <= 1'b1;
				round_no <= 4'd1;
			end else if (active) begin
				if (last_round) begin
					active   <= 1'b0;
					round_no <= '0;
				end else begin
					round_no <= round_no + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			state <= block_in ^ rd_key; // Round 0 is AddRoundKey alone.
		end else if (active) begin
			state <= round_out ^ rd_key;
		end
	end

	assert property (@(posedge clk) disable iff (reset) round_no <= round_t'(`NR))
		else $error("Round counter passed round %0d.", `NR);

endmodule

`default_nettype wire

//--- source/result_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module result_stage (
	input wire                  clk,
	input wire                  reset,
	input wire                  final_valid,
	input wire aes_pkg::block_t final_state,
	output logic                out_valid,
	output aes_pkg::block_t     ciphertext
);
	import aes_pkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= final_valid;
		end
	end

	// The ciphertext stays until the next result replaces it.
	always_ff @(posedge clk) begin
		if (final_valid) begin
			ciphertext <= final_state;
		end
	end

	assert property (@(posedge clk) disable iff (reset) out_valid |=> !out_valid)
		else $error("out_valid held for more than one cycle.");

endmodule

`default_nettype wire

//--- source/aes_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module aes_top (
	input wire                  clk,
	input wire                  reset,
	input wire                  load_key,
	input wire                  encrypt,
	input wire aes_pkg::block_t key,
	input wire aes_pkg::block_t plaintext,
	output wire                 key_ready,
	output wire                 busy,
	output wire                 out_valid,
	output wire aes_pkg::block_t ciphertext
);
	import aes_pkg::*;

	logic   key_start;
	block_t key_in;
	logic   start;
	block_t block_in;
	round_t rd_addr;
	block_t rd_key;
	logic   final_valid;
	block_t final_state;

	round_key_if kif ();

	// Decode stage.
	cmd_decode u_decode (
		.clk       (clk),
		.reset     (reset),
		.load_key  (load_key),
		.encrypt   (encrypt),
		.key       (key),
		.plaintext (plaintext),
		.out_valid (out_valid),
		.kif       (kif),
		.key_start (key_start),
		.key_in    (key_in),
		.start     (start),
		.block_in  (block_in),
		.key_ready (key_ready),
		.busy      (busy)
	);

	round_key u_round_key (
		.clk   (clk),
		.reset (reset),
		.en    (key_start),
		.key   (key_in),
		.kif   (kif)
	);

	key_store u_key_store (
		.clk     (clk),
		.kif     (kif),
		.rd_addr (rd_addr),
		.rd_key  (rd_key)
	);

	// Execute stage.
	cipher_round u_cipher (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.block_in    (block_in),
		.rd_addr     (rd_addr),
		.rd_key      (rd_key),
		.final_valid (final_valid),
		.final_state (final_state)
	);

	result_stage u_result (
		.clk         (clk),
		.reset       (reset),
		.final_valid (final_valid),
		.final_state (final_state),
		.out_valid   (out_valid),
		.ciphertext  (ciphertext)
	);

endmodule

`default_nettype wire

//--- verification/aes_model.svh
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AES-128 encryption as written out in FIPS-197, one block at a time.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic aes_pkg::word_t rot_sub_word(input aes_pkg::word_t w, input aes_pkg::byte_t rc);
	return {aes_pkg::sbox(w[23:16]) ^ rc, aes_pkg::sbox(w[15:8]), aes_pkg::sbox(w[7:0]),
		aes_pkg::sbox(w[31:24])};
endfunction

function automatic aes_pkg::byte_t times3(input aes_pkg::byte_t b);
	return aes_pkg::xtime(b) ^ b;
endfunction

function automatic aes_pkg::block_t aes_encrypt(input aes_pkg::block_t key,
		input aes_pkg::block_t pt);
	aes_pkg::word_t  w [0:43];
	aes_pkg::byte_t  s [0:15];
	aes_pkg::byte_t  t [0:15];
	aes_pkg::byte_t  rc;
	aes_pkg::block_t ct;

	// Key schedule, Nk = 4 words per round key.
	rc = 8'h01;
	for (int i = 0; i < 4; i++) begin
		w[i] = key[127-32*i -: 32];
	end
	for (int i = 4; i < 44; i++) begin
		if (i % 4 == 0) begin
			w[i] = w[i-4] ^ rot_sub_word(w[i-1], rc);
			rc   = aes_pkg::xtime(rc);
		end else begin
			w[i] = w[i-4] ^ w[i-1];
		end
	end

	for (int i = 0; i < 16; i++) begin
		s[i] = pt[127-8*i -: 8] ^ w[i/4][31-8*(i%4) -: 8];
	end

	for (int r = 1; r <= 10; r++) begin
		// Row j of the output column c comes from column c + j.
		for (int c = 0; c < 4; c++) begin
			for (int j = 0; j < 4; j++) begin
				t[4*c+j] = aes_pkg::sbox(s[4*((c+j)%4)+j]);
			end
		end
		for (int c = 0; c < 4; c++) begin
			if (r < 10) begin
				s[4*c]   = aes_pkg::xtime(t[4*c]) ^ times3(t[4*c+1]) ^ t[4*c+2] ^ t[4*c+3];
				s[4*c+1] = t[4*c] ^ aes_pkg::xtime(t[4*c+1]) ^ times3(t[4*c+2]) ^ t[4*c+3];
				s[4*c+2] = t[4*c] ^ t[4*c+1] ^ aes_pkg::xtime(t[4*c+2]) ^ times3(t[4*c+3]);
				s[4*c+3] = times3(t[4*c]) ^ t[4*c+1] ^ t[4*c+2] ^ aes_pkg::xtime(t[4*c+3]);
			end else begin
				for (int j = 0; j < 4; j++) begin
					s[4*c+j] = t[4*c+j];
				end
			end
		end
		for (int i = 0; i < 16; i++) begin
			s[i] = s[i] ^ w[4*r+i/4][31-8*(i%4) -: 8];
		end
	end

	for (int i = 0; i < 16; i++) begin
		ct[127-8*i -: 8] = s[i];
	end
	return ct;
endfunction

`endif

//--- verification/aes_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "aes_params.svh"

module aes_tb;
	import aes_pkg::*;

	`include "aes_model.svh"

	localparam int wait_limit = 100;

	// FIPS-197 appendix B.
	localparam block_t fips_key = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam block_t fips_pt  = 128'h3243f6a8885a308d313198a2e0370734;
	localparam block_t fips_ct  = 128'h3925841d02dc09fbdc118597196a0b32;

	logic        clk;
	logic        reset;
	logic        load_key;
	logic        encrypt;
	block_t      key;
	block_t      plaintext;
	logic        key_ready;
	logic        busy;
	logic        out_valid;
	block_t      ciphertext;

	block_t      exp_ct;      // Ciphertext of the encrypt that was accepted last.
	logic        exp_pending; // High from acceptance until its out_valid has been seen.
	logic [31:0] rng;

	aes_top UUT (
		.clk        (clk),
		.reset      (reset),
		.load_key   (load_key),
		.encrypt    (encrypt),
		.key        (key),
		.plaintext  (plaintext),
		.key_ready  (key_ready),
		.busy       (busy),
		.out_valid  (out_valid),
		.ciphertext (ciphertext)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks on the DUT outputs.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assert property (@(posedge clk) $fell(reset) |-> !key_ready && !busy && !out_valid)
		else abort_run($sformatf("CHECK FAILED at %0t: outputs not idle after reset", $time));

	// Dropped requests must never produce a result.
	assert property (@(posedge clk) disable iff (reset) out_valid |-> exp_pending)
		else abort_run($sformatf("CHECK FAILED at %0t: out_valid with no accepted encrypt",
			$time));

	assert property (@(posedge clk) disable iff (reset) out_valid |-> ciphertext == exp_ct)
		else abort_run($sformatf("CHECK FAILED at %0t: ciphertext %h, expected %h",
			$time, ciphertext, exp_ct));

	assert property (@(posedge clk) disable iff (reset) exp_pending && !out_valid |-> busy)
		else abort_run($sformatf("CHECK FAILED at %0t: busy low during an encryption", $time));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic block_t random_block();
		block_t b;
		for (int i = 0; i < 4; i++) begin
			b[127-32*i -: 32] = next_random();
		end
		return b;
	endfunction

	task automatic load_new_key(input block_t k);
		@(posedge clk);
		key      <= k;
		load_key <= 1'b1;
		@(posedge clk);
		load_key <= 1'b0;
	endtask

	task automatic send_encrypt(input block_t pt, input logic accepted, input block_t expected);
		@(posedge clk);
		plaintext <= pt;
		encrypt   <= 1'b1;
		@(posedge clk);
		encrypt <= 1'b0;
		if (accepted) begin
			exp_ct      <= expected;
			exp_pending <= 1'b1;
		end
	endtask

	task automatic wait_key_ready();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!key_ready && n < wait_limit);
		if (!key_ready) begin
			abort_run("Timeout: the wait for key_ready never ended.");
		end
	endtask

	task automatic wait_out_valid();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!out_valid && n < wait_limit);
		if (!out_valid) begin
			abort_run("Timeout: the wait for out_valid never ended.");
		end
		@(posedge clk);
		exp_pending <= 1'b0; // The result is checked at this edge.
	endtask

	task automatic idle_cycles(input int cycles);
		repeat (cycles) @(negedge clk);
	endtask

	initial begin
		block_t k;
		block_t pt;

		rng         = 32'd91;
		reset       = 1'b1;
		load_key    = 1'b0;
		encrypt     = 1'b0;
		key         = '0;
		plaintext   = '0;
		exp_ct      = '0;
		exp_pending = 1'b0;
		k           = '0;

		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// No key has been loaded, so this encrypt is dropped.
		send_encrypt(fips_pt, 1'b0, '0);
		idle_cycles(wait_limit);

		assert (aes_encrypt(fips_key, fips_pt) == fips_ct)
			else abort_run($sformatf("CHECK FAILED at %0t: model misses the FIPS-197 vector",
				$time));
		load_new_key(fips_key);
		wait_key_ready();
		send_encrypt(fips_pt, 1'b1, fips_ct);
		wait_out_valid();

		for (int i = 0; i < 20; i++) begin
			if (i % 5 == 0) begin
				k = random_block();
				load_new_key(k);
				wait_key_ready();
			end
			pt = random_block();
			send_encrypt(pt, 1'b1, aes_encrypt(k, pt));
			wait_out_valid();
		end

		// An encrypt right behind a key load finds the core expanding.
		k = random_block();
		load_new_key(k);
		send_encrypt(random_block(), 1'b0, '0);
		wait_key_ready();
		idle_cycles(20);

		// The second strobe lands while busy and must leave no trace.
		pt = random_block();
		send_encrypt(pt, 1'b1, aes_encrypt(k, pt));
		send_encrypt(random_block(), 1'b0, '0);
		wait_out_valid();
		idle_cycles(30);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
+incdir+verification
source/aes_pkg.sv
source/round_key_if.sv
source/round_key.sv
source/key_store.sv
source/cmd_decode.sv
source/cipher_round.sv
source/result_stage.sv
source/aes_top.sv
verification/aes_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the AES-128 testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/1ps \
	--top-module aes_tb -f files.f

# The simulation may stop on $fatal, so its status is judged from the log.
./obj_dir/Vaes_tb 2>&1 | tee sim.log || true

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation passed."
	exit 0
else
	echo "Simulation failed, see sim.log."
	exit 1
fi
